/* hw/fetchUnit_consts.svh */
// Fetch and branch unit constants
// Instruction address width, the first fetch address and the opcode
// numbers that the branch decode looks at
`ifndef FETCH_UNIT_CONSTS_SVH
`define FETCH_UNIT_CONSTS_SVH

// Instruction address width in bits, byte address
`define FETCH_AW 24

// Word address of the first fetch after reset
`define RESET_PC 0

// Unconditional branch, register and immediate forms
`define OPC_BRU_A 6'o46
`define OPC_BRU_B 6'o56

// Conditional branch, register and immediate forms
`define OPC_BCC_A 6'o47
`define OPC_BCC_B 6'o57

// Return from subroutine, always delayed
`define OPC_RTD 6'o55

// Immediate prefix, not a branch
`define OPC_IMM 6'o54

`endif

/* hw/fetchPkg.sv */
// Fetch and branch unit types
// Word address, compare condition and forwarding source shared by the
// branch logic, the fetch port and the top level

package fetchPkg;

   // Word address, bits 31 down to 2 of a byte address
   typedef logic [29:0] wordAddr;

   // Compare condition, low three bits of rd on a conditional branch
   // Codes 6 and 7 are undefined and never take the branch
   typedef enum logic [2:0] {
      equal        = 3'd0,
      notEqual     = 3'd1,
      less         = 3'd2,
      lessEqual    = 3'd3,
      greater      = 3'd4,
      greaterEqual = 3'd5
   } cmpCond;

   // Where the compare operand comes from
   // register is the plain register file read
   // aluResult forwards the result of the instruction in execute
   // loadData forwards the word returned by a load
   typedef enum logic [1:0] {
      register  = 2'd0,
      aluResult = 2'd1,
      loadData  = 2'd2
   } opndSrc;

endpackage

/* hw/branchCond.sv */
// Branch condition evaluation
// Picks the compare operand from one of three forwarding sources and
// tests it against zero for the six conditional branch kinds
// Purely combinational
`timescale 1ns/1ps

module branchCond (
   input  fetchPkg::opndSrc opndSel,
   input  logic [31:0]      regA,
   input  logic [31:0]      aluResult,
   input  logic [31:0]      loadData,
   input  fetchPkg::cmpCond cond,
   output logic             condMet
);

   logic [31:0] opnd;
   logic        isZero;
   logic        isNeg;

   // Forwarding mux for the compare operand
   always_comb begin
      case (opndSel)
         fetchPkg::loadData:  opnd = loadData;
         fetchPkg::aluResult: opnd = aluResult;
         default:             opnd = regA;
      endcase
   end

   // Compare is always against zero, so only zero and sign are needed
   assign isZero = (opnd == 32'd0);
   assign isNeg  = opnd[31];

   always_comb begin
      case (cond)
         fetchPkg::equal:        condMet = isZero;
         fetchPkg::notEqual:     condMet = !isZero;
         fetchPkg::less:         condMet = isNeg;
         fetchPkg::lessEqual:    condMet = isNeg | isZero;
         // Greater excludes both negative and zero
         fetchPkg::greater:      condMet = !(isNeg | isZero);
         fetchPkg::greaterEqual: condMet = !isNeg;
         // Undefined codes never branch
         default:                condMet = 1'b0;
      endcase
   end

endmodule

/* hw/branchPcUnit.sv */
// Branch and PC unit
// Decodes branch opcodes into the branch and delay flags and keeps the
// fetch, execute and link program counters
// All registers move only on a pipeline advance
`timescale 1ns/1ps
`include "fetchUnit_consts.svh"

module branchPcUnit (
   input  logic              gclk,
   input  logic              grst,
   input  logic              advance,
   input  logic [5:0]        opcode,
   input  logic [4:0]        rd,
   input  logic [4:0]        ra,
   input  logic              condMet,
   input  logic [31:0]       aluResult,
   output fetchPkg::wordAddr fetchPc,
   output fetchPkg::wordAddr pc,
   output fetchPkg::wordAddr pcLink,
   output logic              branch,
   output logic              delay
);

   logic              isRtd;
   logic              isBcc;
   logic              isBru;
   logic              nextBranch;
   logic              nextDelay;
   fetchPkg::wordAddr nextFetchPc;

   // Branch opcode decode
   assign isRtd = (opcode == `OPC_RTD);
   assign isBcc = (opcode == `OPC_BCC_A) || (opcode == `OPC_BCC_B);
   assign isBru = (opcode == `OPC_BRU_A) || (opcode == `OPC_BRU_B);

   // Flag logic
   always_comb begin
      if (branch) begin
         // Instruction after a taken branch is squashed
         nextBranch = 1'b0;
         nextDelay  = 1'b0;
      end else begin
         // Return and unconditional branch always take
         if (isRtd || isBru) begin
            nextBranch = 1'b1;
         end else if (isBcc) begin
            nextBranch = condMet;
         end else begin
            nextBranch = 1'b0;
         end
         // Delay slot: ra bit 4 for bru, rd bit 4 for bcc, always for rtd
         nextDelay = (isBru & ra[4]) | (isBcc & rd[4]) | isRtd;
      end
   end

   // Target comes from the ALU as a byte address
   assign nextFetchPc = branch ? aluResult[31:2] : fetchPc + 30'd1;

   // PC pipeline and flags
   always_ff @(posedge gclk) begin
      if (grst) begin
         fetchPc <= fetchPkg::wordAddr'(`RESET_PC);
         pc      <= '0;
         pcLink  <= '0;
         branch  <= 1'b0;
         delay   <= 1'b0;
      end else if (advance) begin
         fetchPc <= nextFetchPc;
         // Execute PC trails fetch by one step
         pc      <= fetchPc;
         // Link PC trails execute by one more
         pcLink  <= pc;
         branch  <= nextBranch;
         delay   <= nextDelay;
      end
   end

endmodule

/* hw/instFetchPort.sv */
// Instruction fetch port
// Four-phase req/ack master toward the instruction memory
// Fetches one word per step and pulses advance once the memory has
// released its ack, which moves the whole pipeline on
`timescale 1ns/1ps
`include "fetchUnit_consts.svh"

module instFetchPort (
   input  logic                   gclk,
   input  logic                   grst,
   input  fetchPkg::wordAddr      fetchPc,
   input  logic                   iAck,
   input  logic [31:0]            iData,
   output logic                   iReq,
   output logic [`FETCH_AW-3:0]   iAdr,
   output logic [31:0]            inst,
   output logic                   advance
);

   typedef enum logic [1:0] {
      stRequest     = 2'd0,
      stWaitAck     = 2'd1,
      stWaitRelease = 2'd2,
      stAdvance     = 2'd3
   } fetchState;

   fetchState state;

   // fetchPc only moves on advance, when req and ack are both low
   assign iAdr = fetchPc[`FETCH_AW-3:0];

   // Handshake FSM
   always_ff @(posedge gclk) begin
      if (grst) begin
         state   <= stRequest;
         iReq    <= 1'b0;
         advance <= 1'b0;
      end else begin
         case (state)
            // First request after reset
            stRequest: begin
               iReq  <= 1'b1;
               state <= stWaitAck;
            end
            // Hold req until memory answers
            stWaitAck: begin
               if (iAck) begin
                  iReq  <= 1'b0;
                  state <= stWaitRelease;
               end
            end
            // Wait for ack to drop, then advance
            stWaitRelease: begin
               if (!iAck) begin
                  advance <= 1'b1;
                  state   <= stAdvance;
               end
            end
            // One cycle advance, next request starts with the new PC
            stAdvance: begin
               advance <= 1'b0;
               iReq    <= 1'b1;
               state   <= stWaitAck;
            end
            default: state <= stRequest;
         endcase
      end
   end

   // Capture the word with the ack
   always_ff @(posedge gclk) begin
      if (state == stWaitAck && iAck) begin
         inst <= iData;
      end
   end

endmodule

/* hw/fetchTop.sv */
// Fetch and branch subsystem top level
// Condition evaluation, branch and PC unit and the instruction memory
// port, stepped by the advance pulse from the port
`timescale 1ns/1ps
`include "fetchUnit_consts.svh"

module fetchTop (
   input  logic                 gclk,
   input  logic                 grst,
   // Decode stage
   input  logic [5:0]           opcode,
   input  logic [4:0]           rd,
   input  logic [4:0]           ra,
   input  fetchPkg::opndSrc     opndSel,
   input  logic [31:0]          regA,
   input  logic [31:0]          aluResult,
   input  logic [31:0]          loadData,
   // Instruction memory
   output logic                 iReq,
   output logic [`FETCH_AW-3:0] iAdr,
   input  logic                 iAck,
   input  logic [31:0]          iData,
   // Results
   output logic [31:0]          inst,
   output logic                 advance,
   output fetchPkg::wordAddr    pc,
   output fetchPkg::wordAddr    pcLink,
   output logic                 branch,
   output logic                 delay
);

   fetchPkg::cmpCond  cond;
   logic              condMet;
   fetchPkg::wordAddr fetchPc;

   // Condition code sits in the low bits of rd
   assign cond = fetchPkg::cmpCond'(rd[2:0]);

   branchCond cond0 (
      .opndSel   (opndSel),
      .regA      (regA),
      .aluResult (aluResult),
      .loadData  (loadData),
      .cond      (cond),
      .condMet   (condMet)
   );

   branchPcUnit bpcu0 (
      .gclk      (gclk),
      .grst      (grst),
      .advance   (advance),
      .opcode    (opcode),
      .rd        (rd),
      .ra        (ra),
      .condMet   (condMet),
      .aluResult (aluResult),
      .fetchPc   (fetchPc),
      .pc        (pc),
      .pcLink    (pcLink),
      .branch    (branch),
      .delay     (delay)
   );

   instFetchPort ifp0 (
      .gclk    (gclk),
      .grst    (grst),
      .fetchPc (fetchPc),
      .iAck    (iAck),
      .iData   (iData),
      .iReq    (iReq),
      .iAdr    (iAdr),
      .inst    (inst),
      .advance (advance)
   );

endmodule

/* sim/fetchTop_chk.sv */
// Fetch subsystem protocol checker
// Concurrent assertions on the instruction memory handshake, the
// advance pulse and the request line during reset
`timescale 1ns/1ps
`include "fetchUnit_consts.svh"

module fetchTopChk (
   input logic                 gclk,
   input logic                 grst,
   input logic                 iReq,
   input logic                 iAck,
   input logic                 advance,
   input logic [`FETCH_AW-3:0] iAdr
);

   // Number of assertion failures so far
   int assertFails = 0;

   // Address may only move while req and ack are both low
   adrStable: assert property (@(posedge gclk) disable iff (grst)
      !$stable(iAdr) |-> $past(!iReq && !iAck))
      else begin
         assertFails++;
         $error("iAdr changed while a fetch handshake was active");
      end

   // Advance is a single cycle pulse
   advanceOneCycle: assert property (@(posedge gclk) disable iff (grst)
      advance |=> !advance)
      else begin
         assertFails++;
         $error("advance stayed high for more than one cycle");
      end

   // Advance comes right after ack was released
   advanceAfterAck: assert property (@(posedge gclk) disable iff (grst)
      advance |-> $past(!iAck) && $past(iAck, 2))
      else begin
         assertFails++;
         $error("advance rose without a preceding falling iAck");
      end

   // No request while reset is held
   reqLowInReset: assert property (@(posedge gclk)
      grst |=> !iReq)
      else begin
         assertFails++;
         $error("iReq was high during reset");
      end

endmodule

bind fetchTop fetchTopChk chk0 (
   .gclk    (gclk),
   .grst    (grst),
   .iReq    (iReq),
   .iAck    (iAck),
   .advance (advance),
   .iAdr    (iAdr)
);

/* sim/fetchTb.sv */
// Fetch subsystem testbench
// Plays the decode stage and the instruction memory, predicts flags,
// PCs and fetched words with a reference model and compares them
// on the cycle after every advance
`timescale 1ns/1ps
`include "fetchUnit_consts.svh"

module fetchTb;

   localparam int numSteps  = 400;
   localparam int waitLimit = 50;

   typedef struct packed {
      logic              branch;
      logic              delay;
      fetchPkg::wordAddr fetchPc;
      fetchPkg::wordAddr pc;
      fetchPkg::wordAddr pcLink;
   } modelState;

   logic                 gclk = 1'b0;
   logic                 grst;
   logic [5:0]           opcode;
   logic [4:0]           rd;
   logic [4:0]           ra;
   fetchPkg::opndSrc     opndSel;
   logic [31:0]          regA;
   logic [31:0]          aluResult;
   logic [31:0]          loadData;
   logic                 iReq;
   logic [`FETCH_AW-3:0] iAdr;
   logic                 iAck;
   logic [31:0]          iData;
   logic [31:0]          inst;
   logic                 advance;
   fetchPkg::wordAddr    pc;
   fetchPkg::wordAddr    pcLink;
   logic                 branch;
   logic                 delay;

   int          checks     = 0;
   int          mismatches = 0;
   int          timeouts   = 0;
   modelState   model;
   modelState   expQ[$];
   logic [31:0] instQ[$];

   fetchTop dut0 (.*);

   always #5 gclk = ~gclk;

   // Memory contents depend on every address bit
   function automatic logic [31:0] memWord(input logic [`FETCH_AW-3:0] adr);
      return {adr[9:0], adr} ^ 32'h5a3c_96e1;
   endfunction

   // Signed compare of the operand against zero
   function automatic logic condHolds(input logic [2:0] code, input logic [31:0] v);
      case (code)
         3'd0:    return v == 32'd0;
         3'd1:    return v != 32'd0;
         3'd2:    return $signed(v) < 0;
         3'd3:    return $signed(v) <= 0;
         3'd4:    return $signed(v) > 0;
         3'd5:    return $signed(v) >= 0;
         default: return 1'b0;
      endcase
   endfunction

   // Expected state after one advance with the given decode inputs
   function automatic modelState nextState(input modelState cur, input logic [5:0] opc,
         input logic [4:0] rdV, input logic [4:0] raV, input fetchPkg::opndSrc sel,
         input logic [31:0] regV, input logic [31:0] aluV, input logic [31:0] ldV);
      modelState   nxt;
      logic [31:0] opnd;
      logic        uncond;
      logic        condBr;
      uncond = (opc == `OPC_BRU_A) || (opc == `OPC_BRU_B);
      condBr = (opc == `OPC_BCC_A) || (opc == `OPC_BCC_B);
      opnd = (sel == fetchPkg::loadData) ? ldV : (sel == fetchPkg::aluResult) ? aluV : regV;
      nxt.branch = 1'b0;
      nxt.delay  = 1'b0;
      // A pending branch squashes whatever comes next
      if (!cur.branch) begin
         if (opc == `OPC_RTD) begin
            nxt.branch = 1'b1;
            nxt.delay  = 1'b1;
         end else if (uncond) begin
            nxt.branch = 1'b1;
            nxt.delay  = raV[4];
         end else if (condBr) begin
            nxt.branch = condHolds(rdV[2:0], opnd);
            nxt.delay  = rdV[4];
         end
      end
      nxt.fetchPc = cur.branch ? aluV[31:2] : cur.fetchPc + 30'd1;
      nxt.pc      = cur.fetchPc;
      nxt.pcLink  = cur.pc;
      return nxt;
   endfunction

   task automatic checkValue(input string what, input logic [31:0] got,
         input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic finishRun();
      $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
         checks, mismatches, timeouts, dut0.chk0.assertFails);
      if (mismatches == 0 && timeouts == 0 && dut0.chk0.assertFails == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   endtask

   task automatic reportTimeout(input string what);
      timeouts++;
      $display("TIMEOUT at %0t: %s", $time, what);
      finishRun();
   endtask

   // Zero, negative or positive with equal chance
   function automatic logic [31:0] pickOperand();
      case ($urandom_range(2))
         0:       return 32'd0;
         1:       return {1'b1, 31'($urandom)};
         default: return {1'b0, 31'($urandom)};
      endcase
   endfunction

   task automatic randomizeDecode();
      case ($urandom_range(9))
         0:       opcode <= `OPC_BRU_A;
         1:       opcode <= `OPC_BRU_B;
         2, 3:    opcode <= `OPC_BCC_A;
         4:       opcode <= `OPC_BCC_B;
         5:       opcode <= `OPC_RTD;
         6:       opcode <= `OPC_IMM;
         default: opcode <= 6'($urandom);
      endcase
      rd        <= 5'($urandom);
      ra        <= 5'($urandom);
      opndSel   <= fetchPkg::opndSrc'(2'($urandom_range(2)));
      regA      <= pickOperand();
      aluResult <= pickOperand();
      loadData  <= pickOperand();
   endtask

   task automatic waitForAdvance();
      int cnt;
      cnt = 0;
      do begin
         @(posedge gclk);
         cnt++;
         if (cnt > waitLimit) reportTimeout("advance never pulsed");
      end while (advance !== 1'b1);
   endtask

   // Decode stage stimulus and expected state bookkeeping
   initial begin : driveDecode
      int          cnt;
      logic [31:0] expInst;
      void'($urandom(32'hc3e));
      grst      = 1'b1;
      opcode    = 6'd0;
      rd        = 5'd0;
      ra        = 5'd0;
      opndSel   = fetchPkg::register;
      regA      = 32'd0;
      aluResult = 32'd0;
      loadData  = 32'd0;
      iAck      = 1'b0;
      iData     = 32'd0;
      model     = '{1'b0, 1'b0, fetchPkg::wordAddr'(`RESET_PC), 30'd0, 30'd0};
      repeat (10) @(posedge gclk);
      grst <= 1'b0;
      randomizeDecode();
      cnt = 0;
      while (iReq !== 1'b1) begin
         @(posedge gclk);
         cnt++;
         if (cnt > waitLimit) reportTimeout("first fetch request never came");
      end
      // Request is raised in the first cycle out of reset and seen one edge later
      checkValue("edges from reset release to first request", cnt, 2);
      checkValue("first request address", iAdr, `RESET_PC);
      for (int step = 0; step < numSteps; step++) begin
         waitForAdvance();
         // Word fetched in this step came from the pre-advance fetch PC
         expInst = memWord(model.fetchPc[`FETCH_AW-3:0]);
         model = nextState(model, opcode, rd, ra, opndSel, regA, aluResult, loadData);
         expQ.push_back(model);
         instQ.push_back(expInst);
         randomizeDecode();
      end
      repeat (2) @(posedge gclk);
      finishRun();
   end

   // Instruction memory with random ack and release delays
   initial begin : memResponder
      int cnt;
      @(posedge gclk);
      forever begin
         cnt = 0;
         while (iReq !== 1'b1) begin
            @(posedge gclk);
            cnt++;
            if (cnt > waitLimit) reportTimeout("memory saw no fetch request");
         end
         repeat ($urandom_range(5)) @(posedge gclk);
         iAck  <= 1'b1;
         iData <= memWord(iAdr);
         cnt = 0;
         while (iReq !== 1'b0) begin
            @(posedge gclk);
            cnt++;
            if (cnt > waitLimit) reportTimeout("iReq stayed high after ack");
         end
         repeat ($urandom_range(5)) @(posedge gclk);
         iAck <= 1'b0;
      end
   end

   // Outputs are settled on the cycle after an advance
   always @(posedge gclk) begin : compareOutputs
      logic        advSeen;
      modelState   exp;
      logic [31:0] expInst;
      if (grst) begin
         advSeen = 1'b0;
      end else begin
         if (advSeen === 1'b1) begin
            if (expQ.size() == 0) begin
               mismatches++;
               $display("ERROR at %0t: advance seen with no expected state queued", $time);
            end else begin
               exp     = expQ.pop_front();
               expInst = instQ.pop_front();
               checkValue("branch", branch, exp.branch);
               checkValue("delay", delay, exp.delay);
               checkValue("fetch address", iAdr, exp.fetchPc[`FETCH_AW-3:0]);
               checkValue("pc", pc, exp.pc);
               checkValue("pcLink", pcLink, exp.pcLink);
               checkValue("inst", inst, expInst);
            end
         end
         advSeen = advance;
      end
   end

endmodule

/* verilog.f */
+incdir+hw
hw/fetchPkg.sv
hw/branchCond.sv
hw/branchPcUnit.sv
hw/instFetchPort.sv
hw/fetchTop.sv
sim/fetchTop_chk.sv
sim/fetchTb.sv
